// ==== source/neo_pkg.sv ====
package neo_pkg;

	// Header size field, also used for the address masks
	typedef logic [31:0] rom_size_t;

	// Byte address within the .NEO file
	typedef logic [26:0] file_addr_t;

	// Byte offset within the current region
	typedef logic [25:0] offset_t;

	// Byte addresses on the two SDRAM write ports
	typedef logic [23:0] bank3_addr_t;
	typedef logic [25:0] bank012_addr_t;

	// Regions in file order
	typedef enum logic [2:0] {
		REG_P    = 3'd0,
		REG_S    = 3'd1,
		REG_M    = 3'd2,
		REG_V1   = 3'd3,
		REG_V2   = 3'd4,
		REG_C    = 3'd5,
		REG_DONE = 3'd6
	} rom_region_e;

	typedef enum logic [1:0] {
		ST_ACCEPT    = 2'd0,
		ST_WAIT_ACK  = 2'd1,
		ST_CHECK_END = 2'd2,
		ST_DONE      = 2'd3
	} load_state_e;

	// .NEO header layout
	localparam int unsigned HEADER_BYTES     = 4096;
	localparam int unsigned SIZE_FIELD_FIRST = 4;
	localparam int unsigned SIZE_FIELD_LAST  = 27;

	// Bank 3 memory map
	localparam bank3_addr_t FIX_BASE  = 24'hE00000;
	localparam bank3_addr_t MROM_BASE = 24'hF00000;

	// Second P bank exists above this size
	localparam rom_size_t PROM_SPLIT = 32'h0010_0000;

endpackage

// ==== source/neo_cfg_if.sv ====
`timescale 1ns/1ps

interface neo_cfg_if;

	neo_pkg::rom_size_t p_size;
	neo_pkg::rom_size_t s_size;
	neo_pkg::rom_size_t m_size;
	neo_pkg::rom_size_t v1_size;
	neo_pkg::rom_size_t v2_size;
	neo_pkg::rom_size_t c_size;
	logic               skip_adpcm;
	// High in the cycle the last header byte is taken
	logic               header_done;

	modport regs (
		output p_size, s_size, m_size, v1_size, v2_size, c_size, skip_adpcm, header_done
	);

	modport seq (
		input p_size, s_size, m_size, v1_size, v2_size, c_size, skip_adpcm, header_done
	);

	modport router (
		input c_size, v1_size, skip_adpcm
	);

endinterface

// ==== source/neo_wr_if.sv ====
`timescale 1ns/1ps

interface neo_wr_if;

	logic                  valid;
	logic                  ready;
	neo_pkg::rom_region_e  region;
	neo_pkg::offset_t      offset;
	logic [7:0]            data;
	// Low file address bits for the C-ROM swizzle
	logic [6:0]            file_lo;

	modport seq (
		output valid, region, offset, data, file_lo,
		input  ready
	);

	modport router (
		input  valid, region, offset, data, file_lo,
		output ready
	);

endinterface

// ==== source/neo_header_regs.sv ====
`timescale 1ns/1ps

module neo_header_regs (
	input  logic                 CLK_48M,
	input  logic                 rst_n,
	input  logic                 byte_take,
	input  neo_pkg::file_addr_t  file_addr,
	input  logic [7:0]           byte_data,
	input  logic                 skip_adpcm_req,
	neo_cfg_if.regs              cfg,
	output neo_pkg::rom_size_t   c_mask,
	output neo_pkg::rom_size_t   v1_mask,
	output neo_pkg::rom_size_t   v2_mask,
	output neo_pkg::rom_size_t   p2_mask,
	output logic                 pcm_merged,
	output logic                 adpcm_en
);

	logic in_size_field;
	logic last_byte;

	// Next power of two at or above size, minus one
	function automatic neo_pkg::rom_size_t size_mask(input neo_pkg::rom_size_t size);
		neo_pkg::rom_size_t m;
		m = size - 32'd1;
		for (int sh = 1; sh < 32; sh = sh * 2) begin
			m = m | (m >> sh);
		end
		if (size == '0) begin
			m = '0;
		end
		return m;
	endfunction

	assign in_size_field = file_addr >= neo_pkg::file_addr_t'(neo_pkg::SIZE_FIELD_FIRST) &&
		file_addr <= neo_pkg::file_addr_t'(neo_pkg::SIZE_FIELD_LAST);
	assign last_byte = file_addr == neo_pkg::file_addr_t'(neo_pkg::HEADER_BYTES - 1);

	assign cfg.header_done = byte_take && last_byte;

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			cfg.p_size     <= '0;
			cfg.s_size     <= '0;
			cfg.m_size     <= '0;
			cfg.v1_size    <= '0;
			cfg.v2_size    <= '0;
			cfg.c_size     <= '0;
			cfg.skip_adpcm <= 1'b0;
		end else if (byte_take) begin
			if (file_addr == '0) begin
				cfg.skip_adpcm <= skip_adpcm_req;
			end
			// Little-endian fields, so each byte enters at the top of C and ripples down
			if (in_size_field) begin
				{cfg.c_size, cfg.v2_size, cfg.v1_size, cfg.m_size, cfg.s_size, cfg.p_size} <=
					{byte_data, cfg.c_size, cfg.v2_size, cfg.v1_size, cfg.m_size,
					cfg.s_size, cfg.p_size[31:8]};
			end
		end
	end

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			c_mask     <= '0;
			v1_mask    <= '0;
			v2_mask    <= '0;
			p2_mask    <= '0;
			pcm_merged <= 1'b0;
			adpcm_en   <= 1'b0;
		end else if (cfg.header_done) begin
			c_mask  <= size_mask(cfg.c_size);
			v1_mask <= size_mask(cfg.v1_size);
			v2_mask <= size_mask(cfg.v2_size);
			if (cfg.p_size > neo_pkg::PROM_SPLIT) begin
				p2_mask <= size_mask(cfg.p_size - neo_pkg::PROM_SPLIT);
			end else begin
				p2_mask <= '0;
			end
			// No V2 data means ADPCM-A and ADPCM-B share V1
			pcm_merged <= cfg.v2_size == '0;
			adpcm_en   <= !cfg.skip_adpcm;
		end
	end

endmodule

// ==== source/neo_load_sequencer.sv ====
`timescale 1ns/1ps

module neo_load_sequencer (
	input  logic                 CLK_48M,
	input  logic                 rst_n,
	input  logic                 load_active,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  neo_pkg::file_addr_t  in_addr,
	input  logic [7:0]           in_data,
	output logic                 byte_take,
	neo_cfg_if.seq               cfg,
	neo_wr_if.seq                wr
);

	neo_pkg::load_state_e state;
	neo_pkg::rom_region_e region;
	neo_pkg::offset_t     offset;
	neo_pkg::rom_size_t   region_size;
	logic                 is_header;
	logic                 write_due;

	always_comb begin
		case (region)
			neo_pkg::REG_P:  region_size = cfg.p_size;
			neo_pkg::REG_S:  region_size = cfg.s_size;
			neo_pkg::REG_M:  region_size = cfg.m_size;
			neo_pkg::REG_V1: region_size = cfg.v1_size;
			neo_pkg::REG_V2: region_size = cfg.v2_size;
			neo_pkg::REG_C:  region_size = cfg.c_size;
			default:         region_size = '0;
		endcase
	end

	assign is_header = in_addr < neo_pkg::file_addr_t'(neo_pkg::HEADER_BYTES);

	// V1 and V2 are still counted in skip mode, just not written
	assign write_due = (region inside {neo_pkg::REG_P, neo_pkg::REG_S, neo_pkg::REG_M,
		neo_pkg::REG_C}) ||
		((region inside {neo_pkg::REG_V1, neo_pkg::REG_V2}) && !cfg.skip_adpcm);

	assign in_ready = (state == neo_pkg::ST_ACCEPT && wr.ready) ||
		state == neo_pkg::ST_DONE;
	assign byte_take = in_valid && in_ready && load_active;

	assign wr.valid   = state == neo_pkg::ST_ACCEPT && in_valid && load_active &&
		!is_header && write_due;
	assign wr.region  = region;
	assign wr.offset  = offset;
	assign wr.data    = in_data;
	assign wr.file_lo = in_addr[6:0];

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			state  <= neo_pkg::ST_ACCEPT;
			region <= neo_pkg::REG_P;
			offset <= '0;
		end else begin
			case (state)
				neo_pkg::ST_ACCEPT: begin
					if (byte_take) begin
						if (is_header) begin
							region <= neo_pkg::REG_P;
							offset <= '0;
							if (cfg.header_done) begin
								state <= neo_pkg::ST_CHECK_END;
							end
						end else if (write_due) begin
							state <= neo_pkg::ST_WAIT_ACK;
						end else begin
							offset <= offset + 26'd1;
							state  <= neo_pkg::ST_CHECK_END;
						end
					end
				end
				// Port valid is up, ready here means the write retires
				neo_pkg::ST_WAIT_ACK: begin
					if (wr.ready) begin
						offset <= offset + 26'd1;
						state  <= neo_pkg::ST_CHECK_END;
					end
				end
				neo_pkg::ST_CHECK_END: begin
					if (region == neo_pkg::REG_DONE) begin
						state <= neo_pkg::ST_DONE;
					end else if ({6'd0, offset} == region_size) begin
						offset <= '0;
						region <= neo_pkg::rom_region_e'(region + 3'd1);
						if (region == neo_pkg::REG_C) begin
							state <= neo_pkg::ST_DONE;
						end
					end else begin
						state <= neo_pkg::ST_ACCEPT;
					end
				end
				default: begin
					if (!load_active) begin
						state  <= neo_pkg::ST_ACCEPT;
						region <= neo_pkg::REG_P;
						offset <= '0;
					end else if (byte_take) begin
						state <= neo_pkg::ST_CHECK_END;
					end
				end
			endcase
		end
	end

endmodule

// ==== source/neo_port_router.sv ====
`timescale 1ns/1ps

module neo_port_router (
	input  logic         CLK_48M,
	input  logic         rst_n,
	neo_cfg_if.router    cfg,
	neo_wr_if.router     wr,
	output logic         p1_valid,
	output logic         p2_valid,
	input  logic         p1_ready,
	input  logic         p2_ready,
	output logic [22:0]  p1_addr,
	output logic [24:0]  p2_addr,
	output logic [15:0]  p1_data,
	output logic [15:0]  p2_data,
	output logic [1:0]   p1_be,
	output logic [1:0]   p2_be
);

	neo_pkg::bank3_addr_t   p1_byte;
	neo_pkg::bank012_addr_t p2_byte;
	logic                   sel_p1;
	logic                   sel_p2;
	logic                   p1_free;
	logic                   p2_free;
	logic                   take_p1;
	logic                   take_p2;

	// Bank 3 layout
	always_comb begin
		case (wr.region)
			neo_pkg::REG_S: p1_byte = neo_pkg::FIX_BASE + neo_pkg::bank3_addr_t'({wr.offset[18:5],
				wr.offset[2:0], ~wr.offset[4], wr.offset[3]});
			neo_pkg::REG_M: p1_byte = neo_pkg::MROM_BASE | wr.offset[23:0];
			default:        p1_byte = wr.offset[23:0];
		endcase
	end

	// Bank 0..2 holds C, then V1, then V2
	always_comb begin
		case (wr.region)
			neo_pkg::REG_V1: p2_byte = cfg.c_size[25:0] + wr.offset;
			neo_pkg::REG_V2: p2_byte = cfg.c_size[25:0] + cfg.v1_size[25:0] + wr.offset;
			default:         p2_byte = {wr.offset[25:7], wr.file_lo[5:2], ~wr.file_lo[6],
				wr.file_lo[0], wr.file_lo[1]};
		endcase
	end

	assign sel_p1 = wr.region inside {neo_pkg::REG_P, neo_pkg::REG_S, neo_pkg::REG_M};
	assign sel_p2 = wr.region == neo_pkg::REG_C ||
		((wr.region inside {neo_pkg::REG_V1, neo_pkg::REG_V2}) && !cfg.skip_adpcm);

	// A port is free when empty or handing off this cycle
	assign p1_free = !p1_valid || p1_ready;
	assign p2_free = !p2_valid || p2_ready;

	// Writes that select no port are dropped at once
	assign wr.ready = sel_p1 ? p1_free : (sel_p2 ? p2_free : 1'b1);

	assign take_p1 = wr.valid && wr.ready && sel_p1;
	assign take_p2 = wr.valid && wr.ready && sel_p2;

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			p1_valid <= 1'b0;
			p2_valid <= 1'b0;
		end else begin
			if (take_p1) begin
				p1_valid <= 1'b1;
			end else if (p1_ready) begin
				p1_valid <= 1'b0;
			end
			if (take_p2) begin
				p2_valid <= 1'b1;
			end else if (p2_ready) begin
				p2_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (take_p1) begin
			p1_addr <= p1_byte[23:1];
			p1_be   <= {p1_byte[0], ~p1_byte[0]};
			p1_data <= {wr.data, wr.data};
		end
		if (take_p2) begin
			p2_addr <= p2_byte[25:1];
			p2_be   <= {p2_byte[0], ~p2_byte[0]};
			p2_data <= {wr.data, wr.data};
		end
	end

endmodule

// ==== source/neo_cart_loader.sv ====
`timescale 1ns/1ps

module neo_cart_loader (
	input  logic                 CLK_48M,
	input  logic                 rst_n,
	input  logic                 load_active,
	input  logic                 skip_adpcm,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  neo_pkg::file_addr_t  in_addr,
	input  logic [7:0]           in_data,
	// Bank 3 write port
	output logic                 p1_valid,
	input  logic                 p1_ready,
	output logic [22:0]          p1_addr,
	output logic [15:0]          p1_data,
	output logic [1:0]           p1_be,
	// Bank 0..2 write port
	output logic                 p2_valid,
	input  logic                 p2_ready,
	output logic [24:0]          p2_addr,
	output logic [15:0]          p2_data,
	output logic [1:0]           p2_be,
	output neo_pkg::rom_size_t   c_mask,
	output neo_pkg::rom_size_t   v1_mask,
	output neo_pkg::rom_size_t   v2_mask,
	output neo_pkg::rom_size_t   p2_mask,
	output logic                 pcm_merged,
	output logic                 adpcm_en
);

	logic byte_take;

	neo_cfg_if cfg_if ();
	neo_wr_if  wr_if ();

	neo_header_regs header_regs_i (
		.CLK_48M        (CLK_48M),
		.rst_n          (rst_n),
		.byte_take      (byte_take),
		.file_addr      (in_addr),
		.byte_data      (in_data),
		.skip_adpcm_req (skip_adpcm),
		.cfg            (cfg_if.regs),
		.c_mask         (c_mask),
		.v1_mask        (v1_mask),
		.v2_mask        (v2_mask),
		.p2_mask        (p2_mask),
		.pcm_merged     (pcm_merged),
		.adpcm_en       (adpcm_en)
	);

	neo_load_sequencer load_sequencer_i (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.load_active (load_active),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_addr     (in_addr),
		.in_data     (in_data),
		.byte_take   (byte_take),
		.cfg         (cfg_if.seq),
		.wr          (wr_if.seq)
	);

	neo_port_router port_router_i (
		.CLK_48M  (CLK_48M),
		.rst_n    (rst_n),
		.cfg      (cfg_if.router),
		.wr       (wr_if.router),
		.p1_valid (p1_valid),
		.p2_valid (p2_valid),
		.p1_ready (p1_ready),
		.p2_ready (p2_ready),
		.p1_addr  (p1_addr),
		.p2_addr  (p2_addr),
		.p1_data  (p1_data),
		.p2_data  (p2_data),
		.p1_be    (p1_be),
		.p2_be    (p2_be)
	);

endmodule

// ==== verification/tb_neo_ref.svh ====
`ifndef TB_NEO_REF_SVH
`define TB_NEO_REF_SVH

// Region sizes with P in [0] up to C in [5]
typedef neo_pkg::rom_size_t [5:0] size_set_t;

// One write as seen on either port
typedef struct packed {
	logic        port2;
	logic [24:0] addr;
	logic [1:0]  be;
	logic [15:0] data;
} wr_rec_t;

function automatic neo_pkg::rom_size_t data_total(input size_set_t sz);
	neo_pkg::rom_size_t sum;
	sum = '0;
	for (int r = 0; r < 6; r++) begin
		sum += sz[r];
	end
	return sum;
endfunction

// Magic and version, then six little-endian sizes, then filler
function automatic logic [7:0] header_byte(input int unsigned idx, input size_set_t sz);
	int unsigned field;
	int unsigned lane;
	field = (idx - 4) / 4;
	lane = (idx - 4) % 4;
	case (idx)
		0: return 8'h4E;
		1: return 8'h45;
		2: return 8'h4F;
		3: return 8'h01;
		default: begin
			if (idx <= 27) begin
				return sz[field][lane*8 +: 8];
			end
			return idx[7:0] ^ idx[15:8] ^ idx[23:16] ^ idx[31:24] ^ 8'hA5;
		end
	endcase
endfunction

function automatic neo_pkg::rom_size_t ref_mask(input neo_pkg::rom_size_t size);
	logic [32:0] pow;
	pow = 33'd1;
	while (pow < {1'b0, size}) begin
		pow = pow << 1;
	end
	if (size == '0) begin
		return '0;
	end
	return neo_pkg::rom_size_t'(pow - 33'd1);
endfunction

function automatic neo_pkg::rom_size_t ref_p2_mask(input neo_pkg::rom_size_t p_size);
	if (p_size > neo_pkg::PROM_SPLIT) begin
		return ref_mask(p_size - neo_pkg::PROM_SPLIT);
	end
	return '0;
endfunction

// Expected port write for one data byte of a region
function automatic wr_rec_t ref_write(input int region, input int unsigned ofs,
	input int unsigned fa, input logic [7:0] d, input size_set_t sz);
	wr_rec_t     rec;
	int unsigned byte_addr;
	case (region)
		0: byte_addr = ofs;
		1: byte_addr = neo_pkg::FIX_BASE + (((ofs >> 5) & 32'h3FFF) << 5) +
			((ofs & 32'h7) << 2) + (((~ofs >> 4) & 32'h1) << 1) + ((ofs >> 3) & 32'h1);
		2: byte_addr = neo_pkg::MROM_BASE | ofs;
		3: byte_addr = sz[5] + ofs;
		4: byte_addr = sz[5] + sz[3] + ofs;
		default: byte_addr = (((ofs >> 7) & 32'h7FFFF) << 7) | (((fa >> 2) & 32'hF) << 3) |
			(((~fa >> 6) & 32'h1) << 2) | ((fa & 32'h1) << 1) | ((fa >> 1) & 32'h1);
	endcase
	rec.port2 = region >= 3;
	rec.addr  = 25'(byte_addr >> 1);
	rec.be    = byte_addr[0] ? 2'b10 : 2'b01;
	rec.data  = {d, d};
	return rec;
endfunction

`endif

// ==== verification/tb_neo_cart_loader.sv ====
`timescale 1ns/1ps

module tb_neo_cart_loader;

	`include "tb_neo_ref.svh"

	localparam logic [31:0] LCG_SEED   = 32'h1d1b_8526;
	localparam int unsigned TAIL_BYTES = 3;
	// Sizes as {C, V2, V1, M, S, P}
	localparam size_set_t EVEN_SIZES  = {32'd8, 32'd8, 32'd8, 32'd8, 32'd8, 32'd8};
	localparam size_set_t GAP_SIZES   = {32'd16, 32'd0, 32'd6, 32'd4, 32'd0, 32'd8};
	localparam size_set_t SKIP_SIZES  = {32'd12, 32'd5, 32'd7, 32'd4, 32'd4, 32'd4};
	localparam size_set_t BIG_SIZES   = {32'h30_0000, 32'h5, 32'h20_0000, 32'h2_0000,
		32'h6000, 32'h18_0000};
	localparam size_set_t EXACT_SIZES = {32'h40_0000, 32'h10_0001, 32'h1, 32'h0,
		32'h2_0000, 32'h10_0000};

	logic                CLK_48M;
	logic                rst_n;
	logic                load_active;
	logic                skip_adpcm;
	logic                in_valid;
	logic                in_ready;
	neo_pkg::file_addr_t in_addr;
	logic [7:0]          in_data;
	logic                p1_valid;
	logic                p1_ready;
	logic [22:0]         p1_addr;
	logic [15:0]         p1_data;
	logic [1:0]          p1_be;
	logic                p2_valid;
	logic                p2_ready;
	logic [24:0]         p2_addr;
	logic [15:0]         p2_data;
	logic [1:0]          p2_be;
	neo_pkg::rom_size_t  c_mask;
	neo_pkg::rom_size_t  v1_mask;
	neo_pkg::rom_size_t  v2_mask;
	neo_pkg::rom_size_t  p2_mask;
	logic                pcm_merged;
	logic                adpcm_en;

	logic [7:0]  image [0:8191];
	wr_rec_t     exp_q[$];
	wr_rec_t     obs_q[$];
	logic [31:0] rng_state = LCG_SEED;
	logic        backpressure = 1'b0;
	int unsigned err_count = 0;
	int unsigned test_errs = 0;
	int unsigned tests_run = 0;
	int unsigned tests_failed = 0;

	neo_cart_loader neo_cart_loader_i (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			err_count++;
		end
	endtask

	function automatic int unsigned build_image(input size_set_t sz, input logic with_data);
		logic [31:0] s;
		int unsigned len;
		int unsigned i;
		s = LCG_SEED;
		len = neo_pkg::HEADER_BYTES;
		for (i = 0; i < neo_pkg::HEADER_BYTES; i++) begin
			image[i] = header_byte(i, sz);
		end
		if (with_data) begin
			len += data_total(sz) + TAIL_BYTES;
			for (i = neo_pkg::HEADER_BYTES; i < len; i++) begin
				s = lcg_next(s);
				image[i] = s[23:16];
			end
		end
		return len;
	endfunction

	// Walks the regions in file order, V1 and V2 stay silent in skip mode
	function automatic void build_expected(input size_set_t sz, input logic skip);
		int unsigned fa;
		int unsigned ofs;
		int          r;
		fa = neo_pkg::HEADER_BYTES;
		for (r = 0; r < 6; r++) begin
			for (ofs = 0; ofs < sz[r]; ofs++) begin
				if (!(skip && (r == 3 || r == 4))) begin
					exp_q.push_back(ref_write(r, ofs, fa, image[fa], sz));
				end
				fa++;
			end
		end
	endfunction

	task automatic stream_image(input int unsigned len);
		int unsigned i;
		i = 0;
		while (i < len) begin
			in_valid <= 1'b1;
			in_addr  <= neo_pkg::file_addr_t'(i);
			in_data  <= image[i];
			@(posedge CLK_48M);
			if (in_ready) begin
				i++;
			end
		end
		in_valid <= 1'b0;
	endtask

	task automatic run_cart(input size_set_t sz, input logic skip);
		int unsigned len;
		len = build_image(sz, 1'b1);
		build_expected(sz, skip);
		skip_adpcm  <= skip;
		load_active <= 1'b1;
		stream_image(len);
		// in_ready comes back once the loader sits in its done state
		do @(posedge CLK_48M); while (!in_ready);
		load_active <= 1'b0;
		repeat (3) @(posedge CLK_48M);
		check_value("pending writes", exp_q.size(), 0);
	endtask

	task automatic run_header(input size_set_t sz);
		int unsigned len;
		len = build_image(sz, 1'b0);
		skip_adpcm  <= 1'b0;
		load_active <= 1'b1;
		stream_image(len);
		repeat (3) @(posedge CLK_48M);
		load_active <= 1'b0;
		@(posedge CLK_48M);
	endtask

	task automatic check_flags(input size_set_t sz, input logic skip);
		check_value("c_mask", c_mask, ref_mask(sz[5]));
		check_value("v1_mask", v1_mask, ref_mask(sz[3]));
		check_value("v2_mask", v2_mask, ref_mask(sz[4]));
		check_value("p2_mask", p2_mask, ref_p2_mask(sz[0]));
		check_value("pcm_merged", pcm_merged, sz[4] == '0);
		check_value("adpcm_en", adpcm_en, !skip);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_count == test_errs) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_count - test_errs);
		end
		test_errs = err_count;
	endtask

	initial begin
		CLK_48M = 1'b0;
		forever #50 CLK_48M = ~CLK_48M;
	end

	// Port models with LCG back-pressure
	initial begin
		p1_ready = 1'b1;
		p2_ready = 1'b1;
		forever begin
			@(posedge CLK_48M);
			if (p1_valid && p1_ready) begin
				obs_q.push_back({1'b0, 2'b00, p1_addr, p1_be, p1_data});
			end
			if (p2_valid && p2_ready) begin
				obs_q.push_back({1'b1, p2_addr, p2_be, p2_data});
			end
			rng_state = lcg_next(rng_state);
			p1_ready <= !backpressure || rng_state[27];
			p2_ready <= !backpressure || rng_state[29];
		end
	end

	always @(negedge CLK_48M) begin
		wr_rec_t got;
		wr_rec_t want;
		while (obs_q.size() > 0) begin
			got = obs_q.pop_front();
			if (exp_q.size() == 0) begin
				$display("Unexpected write on port %0d at word address %h",
					got.port2 ? 2 : 1, got.addr);
				err_count++;
			end else begin
				want = exp_q.pop_front();
				check_value("port select", got.port2, want.port2);
				check_value(got.port2 ? "p2_addr" : "p1_addr", got.addr, want.addr);
				check_value(got.port2 ? "p2_be" : "p1_be", got.be, want.be);
				check_value(got.port2 ? "p2_data" : "p1_data", got.data, want.data);
			end
		end
	end

	initial begin
		int unsigned budget;
		budget = 20 * (6 * neo_pkg::HEADER_BYTES + 2 * data_total(EVEN_SIZES) +
			data_total(GAP_SIZES) + data_total(SKIP_SIZES) + 4 * TAIL_BYTES);
		repeat (budget) @(posedge CLK_48M);
		$display("Watchdog expired before all tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		rst_n       = 1'b0;
		load_active = 1'b0;
		skip_adpcm  = 1'b0;
		in_valid    = 1'b0;
		in_addr     = '0;
		in_data     = '0;
		repeat (3) @(posedge CLK_48M);
		rst_n <= 1'b1;
		@(posedge CLK_48M);
		check_value("in_ready", in_ready, 1);
		check_value("p1_valid", p1_valid, 0);
		check_value("p2_valid", p2_valid, 0);
		check_value("c_mask", c_mask, 0);
		check_value("v1_mask", v1_mask, 0);
		check_value("v2_mask", v2_mask, 0);
		check_value("p2_mask", p2_mask, 0);
		check_value("pcm_merged", pcm_merged, 0);
		check_value("adpcm_en", adpcm_en, 0);
		end_test("reset state");
		run_cart(EVEN_SIZES, 1'b0);
		check_flags(EVEN_SIZES, 1'b0);
		end_test("all regions 8 bytes");
		run_cart(GAP_SIZES, 1'b0);
		check_flags(GAP_SIZES, 1'b0);
		end_test("empty S and V2");
		run_cart(SKIP_SIZES, 1'b1);
		check_flags(SKIP_SIZES, 1'b1);
		end_test("skip ADPCM");
		run_header(BIG_SIZES);
		check_flags(BIG_SIZES, 1'b0);
		run_header(EXACT_SIZES);
		check_flags(EXACT_SIZES, 1'b0);
		end_test("mask rule");
		backpressure <= 1'b1;
		run_cart(EVEN_SIZES, 1'b0);
		backpressure <= 1'b0;
		check_flags(EVEN_SIZES, 1'b0);
		end_test("port back-pressure");
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+verification
source/neo_pkg.sv
source/neo_cfg_if.sv
source/neo_wr_if.sv
source/neo_header_regs.sv
source/neo_load_sequencer.sv
source/neo_port_router.sv
source/neo_cart_loader.sv
verification/tb_neo_cart_loader.sv

// ==== Makefile ====
TOP := tb_neo_cart_loader
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
